//--- build.f
+incdir+include
source/icache_pkg.sv
source/icache_sram.sv
source/icache_way.sv
source/icache_victim_sel.sv
source/icache_ctrl.sv
source/icache_resp_sel.sv
source/icache_top.sv
tests/tb_icache_mem.sv
tests/tb_icache.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

# the result is taken from the log, not from the exit code
test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_icache
	./obj_dir/Vtb_icache | tee $(LOG)
	@grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/tb_icache.sv
////////////////////////////////////////////////////////////
// instruction cache testbench: clock, reset, stimulus
// table, compare tasks and final report
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

  localparam int WAIT_LIMIT = 200;

  // one table row, exp_reads below zero skips the read count
  typedef struct {
    logic  is_flush;
    addr_t addr;
    word_t exp_word;
    int    exp_reads;
  } row_t;

  logic  clk_i;
  logic  rst_ni;
  logic  req_i;
  addr_t addr_i;
  logic  flush_i;
  logic  ready_o;
  logic  valid_o;
  word_t data_o;
  logic  busy_o;
  logic  wb_cyc_o;
  logic  wb_stb_o;
  addr_t wb_adr_o;
  word_t wb_dat_i;
  logic  wb_ack_i;
  int    read_count;

  row_t  stim_rows [$];
  int    errors;
  int    passed;
  int    failed;
  logic  timed_out;

  icache_top i_dut (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .req_i    ( req_i    ),
    .addr_i   ( addr_i   ),
    .flush_i  ( flush_i  ),
    .ready_o  ( ready_o  ),
    .valid_o  ( valid_o  ),
    .data_o   ( data_o   ),
    .busy_o   ( busy_o   ),
    .wb_cyc_o ( wb_cyc_o ),
    .wb_stb_o ( wb_stb_o ),
    .wb_adr_o ( wb_adr_o ),
    .wb_dat_i ( wb_dat_i ),
    .wb_ack_i ( wb_ack_i )
  );

  tb_icache_mem i_mem (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .wb_cyc_i     ( wb_cyc_o   ),
    .wb_stb_i     ( wb_stb_o   ),
    .wb_adr_i     ( wb_adr_o   ),
    .wb_dat_o     ( wb_dat_i   ),
    .wb_ack_o     ( wb_ack_i   ),
    .read_count_o ( read_count )
  );

  // 8 ns period
  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // expected values
  ////////////////////////////////////////////////////////////

  // word rule on the word-aligned address
  function automatic word_t rule_word(input addr_t a);
    addr_t w;
    w = a & ~addr_t'(3);
    return {w[15:0], ~w[15:0]};
  endfunction

  // k-th bus read: one word for nc, else the aligned line
  function automatic addr_t bus_addr(input addr_t a, input int k);
    if (a[31]) begin
      return a & ~addr_t'(3);
    end
    return (a & ~addr_t'(15)) + addr_t'(4 * k);
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s data %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] %0t: %s bus reads %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_hit_timing(input string what, input int lat);
    if (lat != 1) begin
      $display("[FAIL] %0t: %s hit answered after %0d cycles, expected 1", $time, what, lat);
      errors++;
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s bus address %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////
  task automatic add_fetch(input addr_t a, input int reads);
    row_t r;
    r.is_flush  = 1'b0;
    r.addr      = a;
    r.exp_word  = rule_word(a);
    r.exp_reads = reads;
    stim_rows.push_back(r);
  endtask

  task automatic add_flush();
    row_t r;
    r.is_flush  = 1'b1;
    r.addr      = '0;
    r.exp_word  = '0;
    r.exp_reads = -1;
    stim_rows.push_back(r);
  endtask

  task automatic build_table();
    // cold line, then the rest of it back to back
    add_fetch(32'h0000_1044, 4);
    add_fetch(32'h0000_1040, 0);
    add_fetch(32'h0000_1048, 0);
    // byte offset ignored
    add_fetch(32'h0000_104e, 0);
    add_fetch(32'h0000_1044, 0);
    // noncacheable word, never allocated
    add_fetch(32'h8000_0204, 1);
    add_fetch(32'h8000_0204, 1);
    add_flush();
    add_fetch(32'h0000_1048, 4);
    // four lines in set 0x10 fill all ways
    add_fetch(32'h0000_2104, 4);
    add_fetch(32'h0000_4108, 4);
    add_fetch(32'h0000_610c, 4);
    add_fetch(32'h0000_8100, 4);
    add_fetch(32'h0000_2100, 0);
    add_fetch(32'h0000_4104, 0);
    add_fetch(32'h0000_6108, 0);
    add_fetch(32'h0000_810c, 0);
    // fifth line evicts an unknown way
    add_fetch(32'h0000_a104, 4);
    add_fetch(32'h0000_a108, 0);
    add_fetch(32'h0000_2108, -1);
    add_fetch(32'h0000_410c, -1);
    add_fetch(32'h0000_6100, -1);
    add_fetch(32'h0000_8104, -1);
  endtask

  ////////////////////////////////////////////////////////////
  // bus-level sequences, all on the falling edge
  ////////////////////////////////////////////////////////////
  task automatic reset_and_wait();
    int t;
    t = 0;
    repeat (4) @(negedge clk_i);
    check_flag("reset valid_o", valid_o, 1'b0);
    check_flag("reset ready_o", ready_o, 1'b0);
    check_flag("reset wb_cyc_o", wb_cyc_o, 1'b0);
    check_flag("reset wb_stb_o", wb_stb_o, 1'b0);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // startup flush in progress
    check_flag("flush busy_o", busy_o, 1'b1);
    check_flag("flush ready_o", ready_o, 1'b0);
    while (!ready_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    if (!ready_o) begin
      $display("timeout: cache never became ready after reset");
      timed_out = 1'b1;
    end else begin
      check_flag("idle busy_o", busy_o, 1'b0);
    end
  endtask

  task automatic run_fetch(input addr_t a, output word_t data, output int lat);
    int t;
    data = '0;
    lat  = 0;
    t    = 0;
    // ready_o is stable here, it only moves on the rising edge
    while (!ready_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    if (!ready_o) begin
      $display("timeout: cache not ready for fetch of %h at %0t", a, $time);
      timed_out = 1'b1;
      return;
    end
    req_i  = 1'b1;
    addr_i = a;
    @(negedge clk_i);
    // accepted on the rising edge just passed
    req_i = 1'b0;
    lat   = 1;
    while (!valid_o && lat < WAIT_LIMIT) begin
      @(negedge clk_i);
      lat++;
    end
    if (!valid_o) begin
      $display("timeout: no response for fetch of %h at %0t", a, $time);
      timed_out = 1'b1;
      return;
    end
    data = data_o;
  endtask

  task automatic run_flush();
    int t;
    t       = 0;
    req_i   = 1'b0;
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    // may be held pending until the cache is idle
    while (!busy_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    if (!busy_o) begin
      $display("timeout: flush request never made the cache busy");
      timed_out = 1'b1;
    end
  endtask

  task automatic run_row(input int i);
    row_t  r;
    int    n0;
    int    err0;
    int    lat;
    word_t got;
    string tag;
    r    = stim_rows[i];
    err0 = errors;
    n0   = read_count;
    tag  = $sformatf("row %0d (%h)", i, r.addr);
    if (r.is_flush) begin
      run_flush();
    end else begin
      run_fetch(r.addr, got, lat);
      if (!timed_out) begin
        check_word(tag, got, r.exp_word);
        if (r.exp_reads >= 0) begin
          check_count(tag, read_count - n0, r.exp_reads);
          if (r.exp_reads == 0) begin
            check_hit_timing(tag, lat);
          end else if (read_count - n0 == r.exp_reads) begin
            for (int k = 0; k < r.exp_reads; k++) begin
              check_addr(tag, i_mem.adr_log[(n0 + k) % 16], bus_addr(r.addr, k));
            end
          end
        end
      end
    end
    if (!timed_out && errors == err0) begin
      passed++;
      $display("row %0d %s %h reads %0d: ok", i, r.is_flush ? "flush" : "fetch",
               r.addr, read_count - n0);
    end else begin
      failed++;
      $display("row %0d %s %h reads %0d: failed", i, r.is_flush ? "flush" : "fetch",
               r.addr, read_count - n0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    req_i     = 1'b0;
    addr_i    = '0;
    flush_i   = 1'b0;
    errors    = 0;
    passed    = 0;
    failed    = 0;
    timed_out = 1'b0;
    build_table();
    reset_and_wait();
    $display("reset and startup flush: %s", (errors == 0 && !timed_out) ? "ok" : "failed");
    for (int i = 0; i < stim_rows.size() && !timed_out; i++) begin
      run_row(i);
    end
    req_i = 1'b0;
    $display("summary: %0d rows passed, %0d rows failed, %0d check errors",
             passed, failed, errors);
    if (errors == 0 && failed == 0 && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_icache_mem.sv
////////////////////////////////////////////////////////////
// Wishbone classic slave memory for the cache testbench
// rule-based words, random ack delay, read counter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_icache_mem import icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  addr_t wb_adr_i,
  output word_t wb_dat_o,
  output logic  wb_ack_o,
  output int    read_count_o
);

  // read-only slave, the master's write enable is tied low
  integer     seed = 45;
  logic       active_q;
  logic [1:0] wait_q;
  // bus address of each read, indexed by read number mod 16
  addr_t      adr_log [16];

  // low address half on top, its inverse below
  function automatic word_t mem_word(input addr_t a);
    return {a[15:0], ~a[15:0]};
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q     <= 1'b0;
      wait_q       <= '0;
      wb_ack_o     <= 1'b0;
      wb_dat_o     <= '0;
      read_count_o <= 0;
    end else if (wb_ack_o) begin
      // ack lasts one cycle, the master drops stb on it
      wb_ack_o <= 1'b0;
    end else if (wb_cyc_i && wb_stb_i) begin
      if (!active_q) begin
        // new read, draw 0 to 3 wait states
        active_q <= 1'b1;
        wait_q   <= 2'($unsigned($random(seed)) % 4);
      end else if (wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end else begin
        active_q                   <= 1'b0;
        wb_ack_o                   <= 1'b1;
        wb_dat_o                   <= mem_word(wb_adr_i);
        adr_log[read_count_o[3:0]] <= wb_adr_i;
        read_count_o               <= read_count_o + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/icache_top.sv
////////////////////////////////////////////////////////////
// instruction cache top: controller, ways, victim select,
// response mux
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_top import icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_i,
  input  addr_t addr_i,
  input  logic  flush_i,
  output logic  ready_o,
  output logic  valid_o,
  output word_t data_o,
  output logic  busy_o,
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  output addr_t wb_adr_o,
  input  word_t wb_dat_i,
  input  logic  wb_ack_i
);

  logic                     rd_en, use_refill, victim_adv, any_hit;
  index_t                   index;
  tag_t                     lookup_tag;
  word_sel_t                word_sel;
  way_oh_t                  way_we, way_hit, way_valid, victim;
  tag_entry_t               wr_entry;
  line_t                    wr_line;
  word_t                    refill_word;
  word_t [`ICACHE_WAYS-1:0] way_words;

  icache_ctrl i_ctrl (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .req_i         ( req_i          ),
    .addr_i        ( addr_i         ),
    .flush_i       ( flush_i        ),
    .any_hit_i     ( any_hit        ),
    .victim_i      ( victim         ),
    .all_valid_i   ( &way_valid     ),
    .wb_dat_i      ( wb_dat_i       ),
    .wb_ack_i      ( wb_ack_i       ),
    .ready_o       ( ready_o        ),
    .valid_o       ( valid_o        ),
    .busy_o        ( busy_o         ),
    .rd_en_o       ( rd_en          ),
    .index_o       ( index          ),
    .lookup_tag_o  ( lookup_tag     ),
    .word_sel_o    ( word_sel       ),
    .way_we_o      ( way_we         ),
    .wr_entry_o    ( wr_entry       ),
    .wr_line_o     ( wr_line        ),
    .refill_word_o ( refill_word    ),
    .use_refill_o  ( use_refill     ),
    .victim_adv_o  ( victim_adv     ),
    .wb_cyc_o      ( wb_cyc_o       ),
    .wb_stb_o      ( wb_stb_o       ),
    .wb_adr_o      ( wb_adr_o       )
  );

  // identical ways, only the write enable differs
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_way
    icache_way i_way (
      .clk_i        ( clk_i        ),
      .rd_en_i      ( rd_en        ),
      .we_i         ( way_we[w]    ),
      .index_i      ( index        ),
      .lookup_tag_i ( lookup_tag   ),
      .wr_entry_i   ( wr_entry     ),
      .wr_line_i    ( wr_line      ),
      .word_sel_i   ( word_sel     ),
      .hit_o        ( way_hit[w]   ),
      .valid_o      ( way_valid[w] ),
      .word_o       ( way_words[w] )
    );
  end

  icache_victim_sel i_victim_sel (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .valid_i   ( way_valid  ),
    .advance_i ( victim_adv ),
    .victim_o  ( victim     )
  );

  icache_resp_sel i_resp_sel (
    .hit_i         ( way_hit     ),
    .words_i       ( way_words   ),
    .refill_word_i ( refill_word ),
    .use_refill_i  ( use_refill  ),
    .any_hit_o     ( any_hit     ),
    .data_o        ( data_o      )
  );

endmodule

`default_nettype wire

//--- source/icache_resp_sel.sv
////////////////////////////////////////////////////////////
// response mux: hit reduction, hit word or refill word
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_resp_sel import icache_pkg::*; (
  input  way_oh_t                   hit_i,
  input  word_t [`ICACHE_WAYS-1:0] words_i,
  input  word_t                     refill_word_i,
  input  logic                      use_refill_i,
  output logic                      any_hit_o,
  output word_t                     data_o
);

  word_t hit_word;

  assign any_hit_o = |hit_i;

  // and-or mux, relies on at most one hitting way
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (hit_i[w]) begin
        hit_word = hit_word | words_i[w];
      end
    end
  end

  assign data_o = use_refill_i ? refill_word_i : hit_word;

  // a line is never allocated twice in one set
  always_comb begin
    a_hit_onehot: assert final (use_refill_i || $onehot0(hit_i))
      else $error("more than one way hit");
  end

endmodule

`default_nettype wire

//--- source/icache_ctrl.sv
////////////////////////////////////////////////////////////
// cache controller: FSM, request regs, flush counter,
// refill line buffer and Wishbone classic read master
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  addr_t      addr_i,
  input  logic       flush_i,
  input  logic       any_hit_i,
  input  way_oh_t    victim_i,
  input  logic       all_valid_i,
  input  word_t      wb_dat_i,
  input  logic       wb_ack_i,
  output logic       ready_o,
  output logic       valid_o,
  output logic       busy_o,
  output logic       rd_en_o,
  output index_t     index_o,
  output tag_t       lookup_tag_o,
  output word_sel_t  word_sel_o,
  output way_oh_t    way_we_o,
  output tag_entry_t wr_entry_o,
  output line_t      wr_line_o,
  output word_t      refill_word_o,
  output logic       use_refill_o,
  output logic       victim_adv_o,
  output logic       wb_cyc_o,
  output logic       wb_stb_o,
  output addr_t      wb_adr_o
);

  ctrl_state_e state_d, state_q;
  addr_t       addr_q;
  line_t       line_q;
  index_t      flush_cnt_q;
  word_sel_t   word_cnt_q;
  word_sel_t   slot;
  way_oh_t     victim_q;
  logic        all_valid_q;
  logic        flush_q, flush_pend;
  logic        cyc_q, stb_q, done_q;
  logic        is_nc, hit_ok, miss, last_ack, fill_we;

  assign busy_o     = (state_q != IDLE);
  assign flush_pend = flush_q | flush_i;
  assign is_nc      = addr_q[`ICACHE_NC_BIT];
  // nc lines are never allocated, so a hit there is ignored
  assign hit_ok     = any_hit_i & ~is_nc;
  assign miss       = (state_q == READ) & ~hit_ok;
  // nc reads fetch the requested word only
  assign slot       = is_nc ? addr_q[BYTE_OFF_W +: WORD_OFF_W] : word_cnt_q;
  assign last_ack   = stb_q & wb_ack_i & (is_nc | (&word_cnt_q));
  assign fill_we    = (state_q == REFILL) & done_q & ~is_nc;

  ////////////////////////////////////////////////////////////
  // FSM and handshake
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    ready_o = 1'b0;
    valid_o = 1'b0;
    rd_en_o = 1'b0;
    unique case (state_q)
      // last set cleared, cache usable
      FLUSH: if (&flush_cnt_q) state_d = IDLE;
      IDLE: begin
        if (flush_pend) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          rd_en_o = req_i;
          if (req_i) state_d = READ;
        end
      end
      // tag compare result is valid here
      READ: begin
        if (hit_ok) begin
          valid_o = 1'b1;
          if (flush_pend) begin
            state_d = FLUSH;
          end else begin
            ready_o = 1'b1;
            rd_en_o = req_i;
            state_d = req_i ? READ : IDLE;
          end
        end else begin
          state_d = REFILL;
        end
      end
      // return the word in the cycle after the last ack
      REFILL: begin
        if (done_q) begin
          valid_o = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = FLUSH;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // array access
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (state_q == FLUSH) begin
      index_o = flush_cnt_q;
    end else if (rd_en_o) begin
      index_o = addr_i[INDEX_LSB +: INDEX_W];
    end else begin
      index_o = addr_q[INDEX_LSB +: INDEX_W];
    end
  end

  assign lookup_tag_o  = addr_q[TAG_LSB +: TAG_W];
  assign word_sel_o    = addr_q[BYTE_OFF_W +: WORD_OFF_W];
  // flush writes an invalid entry into every way
  assign way_we_o      = (state_q == FLUSH) ? '1 : (fill_we ? victim_q : '0);
  assign wr_entry_o    = '{valid: (state_q != FLUSH), tag: lookup_tag_o};
  assign wr_line_o     = line_q;
  assign refill_word_o = line_q[word_sel_o];
  assign use_refill_o  = (state_q != READ);
  // the LFSR only moves when it actually picked the victim
  assign victim_adv_o  = fill_we & all_valid_q;

  // Wishbone master outputs
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = stb_q;
  assign wb_adr_o = {addr_q[$bits(addr_t)-1:INDEX_LSB], slot, {BYTE_OFF_W{1'b0}}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      word_cnt_q  <= '0;
      victim_q    <= '0;
      all_valid_q <= 1'b0;
      cyc_q       <= 1'b0;
      stb_q       <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      // pending flush is consumed on entry into FLUSH
      flush_q <= flush_pend & ~((state_d == FLUSH) & (state_q != FLUSH));
      done_q  <= last_ack;
      if (state_q == FLUSH) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
      if (miss) begin
        // start first read, remember the way to fill
        cyc_q       <= 1'b1;
        stb_q       <= 1'b1;
        word_cnt_q  <= '0;
        victim_q    <= victim_i;
        all_valid_q <= all_valid_i;
      end else if (stb_q && wb_ack_i) begin
        // single read ends, bus idles for one cycle
        cyc_q      <= 1'b0;
        stb_q      <= 1'b0;
        word_cnt_q <= word_cnt_q + 1'b1;
      end else if ((state_q == REFILL) && !stb_q && !done_q) begin
        cyc_q <= 1'b1;
        stb_q <= 1'b1;
      end
    end
  end

  // request address and line buffer
  always_ff @(posedge clk_i) begin
    if (rd_en_o) begin
      addr_q <= addr_i;
    end
    if (stb_q && wb_ack_i) begin
      line_q[slot] <= wb_dat_i;
    end
  end

  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o |-> wb_cyc_o)
    else $error("wishbone stb without cyc");

  a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_cyc_o && wb_stb_o && !wb_ack_i) |=> $stable(wb_adr_o))
    else $error("wishbone address changed before ack");

endmodule

`default_nettype wire

//--- source/icache_victim_sel.sv
////////////////////////////////////////////////////////////
// replacement choice: first invalid way, else 8-bit LFSR
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_victim_sel import icache_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  way_oh_t valid_i,
  input  logic    advance_i,
  output way_oh_t victim_o
);

  localparam int unsigned WAY_IDX_W = $clog2(`ICACHE_WAYS);

  logic [7:0] lfsr_q;
  logic       lfsr_fb;
  way_oh_t    first_inv;
  logic       found;

  // lowest numbered invalid way
  always_comb begin
    first_inv = '0;
    found     = 1'b0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (!valid_i[w] && !found) begin
        first_inv[w] = 1'b1;
        found        = 1'b1;
      end
    end
  end

  // taps 8,6,5,4, maximal length
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'ha5;
    end else if (advance_i) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

  assign victim_o = found ? first_inv : way_oh_t'(1) << lfsr_q[WAY_IDX_W-1:0];

  a_victim_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(valid_i) |-> $onehot(victim_o))
    else $error("victim select is not one-hot");

endmodule

`default_nettype wire

//--- source/icache_way.sv
////////////////////////////////////////////////////////////
// one cache way: tag/valid RAM, line RAM, compare, word mux
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_way import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rd_en_i,
  input  logic       we_i,
  input  index_t     index_i,
  input  tag_t       lookup_tag_i,
  input  tag_entry_t wr_entry_i,
  input  line_t      wr_line_i,
  input  word_sel_t  word_sel_i,
  output logic       hit_o,
  output logic       valid_o,
  output word_t      word_o
);

  tag_entry_t rd_entry;
  line_t      rd_line;
  logic       ram_en;

  // both arrays are accessed together
  assign ram_en = rd_en_i | we_i;

  icache_sram #(
    .entry_t ( tag_entry_t  ),
    .DEPTH   ( `ICACHE_SETS )
  ) i_tag_ram (
    .clk_i   ( clk_i      ),
    .en_i    ( ram_en     ),
    .we_i    ( we_i       ),
    .addr_i  ( index_i    ),
    .wdata_i ( wr_entry_i ),
    .rdata_o ( rd_entry   )
  );

  icache_sram #(
    .entry_t ( line_t       ),
    .DEPTH   ( `ICACHE_SETS )
  ) i_data_ram (
    .clk_i   ( clk_i     ),
    .en_i    ( ram_en    ),
    .we_i    ( we_i      ),
    .addr_i  ( index_i   ),
    .wdata_i ( wr_line_i ),
    .rdata_o ( rd_line   )
  );

  // lookup tag is held by the controller for the compare cycle
  assign valid_o = rd_entry.valid;
  assign hit_o   = rd_entry.valid && (rd_entry.tag == lookup_tag_i);
  assign word_o  = rd_line[word_sel_i];

endmodule

`default_nettype wire

//--- source/icache_sram.sv
////////////////////////////////////////////////////////////
// single-port RAM with registered read, generic entry type
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_sram import icache_pkg::*; #(
  parameter type         entry_t = logic,
  parameter int unsigned DEPTH   = 64
) (
  input  logic   clk_i,
  input  logic   en_i,
  input  logic   we_i,
  input  index_t addr_i,
  input  entry_t wdata_i,
  output entry_t rdata_o
);

  entry_t mem_q [DEPTH];

  // write or read, never both in one cycle
  // rdata keeps its last value on a write
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

  a_addr_known: assert property (@(posedge clk_i) en_i |-> !$isunknown(addr_i))
    else $error("sram access with unknown address");

endmodule

`default_nettype wire

//--- source/icache_pkg.sv
////////////////////////////////////////////////////////////
// cache types, address field widths, controller states
////////////////////////////////////////////////////////////

`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  // address split: | tag | index | word | byte |
  localparam int unsigned BYTE_OFF_W = $clog2(`ICACHE_WORD_W / 8);
  localparam int unsigned WORD_OFF_W = $clog2(`ICACHE_LINE_WORDS);
  localparam int unsigned INDEX_W    = $clog2(`ICACHE_SETS);
  localparam int unsigned INDEX_LSB  = BYTE_OFF_W + WORD_OFF_W;
  localparam int unsigned TAG_LSB    = INDEX_LSB + INDEX_W;
  localparam int unsigned TAG_W      = `ICACHE_ADDR_W - TAG_LSB;

  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
  typedef logic [`ICACHE_WORD_W-1:0] word_t;
  // word 0 sits in the low bits
  typedef logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_W-1:0] line_t;
  typedef logic [TAG_W-1:0]          tag_t;
  typedef logic [INDEX_W-1:0]        index_t;
  typedef logic [WORD_OFF_W-1:0]     word_sel_t;
  typedef logic [`ICACHE_WAYS-1:0]   way_oh_t;

  // one tag RAM entry
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  typedef enum logic [1:0] {FLUSH, IDLE, READ, REFILL} ctrl_state_e;

endpackage

`default_nettype wire

//--- include/icache_consts.svh
////////////////////////////////////////////////////////////
// size constants of the instruction cache
// address, word, line, way and set counts, noncacheable bit
////////////////////////////////////////////////////////////

`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// byte address width
`define ICACHE_ADDR_W 32
// fetch word width
`define ICACHE_WORD_W 32
// words per cache line
`define ICACHE_LINE_WORDS 4
// associativity
`define ICACHE_WAYS 4
// sets per way, one entry per set
`define ICACHE_SETS 64
// address bit that selects the noncacheable region
`define ICACHE_NC_BIT 31

`endif
